// ==== design/armCore_defs.svh ====
// Widths and encodings shared by the core and its testbench
// Only the ADD/SUB/AND/ORR, LDR/STR and B subset is encoded here
`ifndef ARM_CORE_DEFS_SVH
`define ARM_CORE_DEFS_SVH

// Datapath widths
`define ARM_XLEN        32
`define ARM_REG_ADDR_W  4
`define ARM_IMM_W       24          // Widest immediate field, branch offset

// Register file
`define ARM_PC_REG      4'd15       // R15 reads as PC+8

// Program counter
`define ARM_PC_STEP     32'd4
`define ARM_RESET_PC    32'h0000_0000

// Instr[27:26] op field
`define ARM_OP_DP       2'b00
`define ARM_OP_MEM      2'b01
`define ARM_OP_BR       2'b10

// Instr[24:21] cmd field of data processing
`define ARM_CMD_AND     4'b0000
`define ARM_CMD_SUB     4'b0010
`define ARM_CMD_ADD     4'b0100
`define ARM_CMD_ORR     4'b1100

// Instr[31:28] cond field
`define ARM_COND_AL     4'b1110

`endif

// ==== design/armCorePkg.sv ====
// Vector types and small select encodings used across the core
// Flag order is N Z C V from MSB to LSB
`include "armCore_defs.svh"

package armCorePkg;

   typedef logic [`ARM_XLEN-1:0]       armWord_t;      // Data, address or instruction
   typedef logic [`ARM_REG_ADDR_W-1:0] armRegAddr_t;   // R0..R15
   typedef logic [3:0]                 armFlags_t;     // N Z C V
   typedef logic [3:0]                 armCond_t;      // Instr[31:28]
   typedef logic [1:0]                 armAluCtrl_t;
   typedef logic [1:0]                 armImmSrc_t;
   typedef logic [1:0]                 armFlagWrite_t; // [1] NZ, [0] CV

   // ALU operation select
   localparam armAluCtrl_t ALU_ADD = 2'b00;
   localparam armAluCtrl_t ALU_SUB = 2'b01;   // Low bit set means b inverted
   localparam armAluCtrl_t ALU_AND = 2'b10;
   localparam armAluCtrl_t ALU_ORR = 2'b11;

   // Immediate extension select
   localparam armImmSrc_t IMM_DP8  = 2'b00;   // Zero-extended imm8
   localparam armImmSrc_t IMM_MEM12 = 2'b01;  // Zero-extended imm12
   localparam armImmSrc_t IMM_BR24 = 2'b10;   // Sign-extended word offset

   // Flag write enable bits
   localparam int FLAG_NZ = 1;
   localparam int FLAG_CV = 0;

endpackage

// ==== design/armDecoder.sv ====
// Combinational main and ALU decoder
// Op 11 and unlisted cmd values are not part of the subset; cmd falls back to ADD
`timescale 1ns/1ps
`include "armCore_defs.svh"

module armDecoder
   import armCorePkg::*;
(
   input  logic [1:0]    op,
   input  logic [5:0]    funct,
   input  armRegAddr_t   rd,
   output logic          regWriteRaw,
   output logic          memWriteRaw,
   output logic          pcWriteRaw,
   output logic          memToReg,
   output logic          aluSrc,
   output logic [1:0]    regSrc,
   output armImmSrc_t    immSrc,
   output armAluCtrl_t   aluCtrl,
   output armFlagWrite_t flagWriteRaw
);

   logic branch;     // B instruction
   logic aluOp;      // Data processing, ALU decoder active
   logic isArith;    // ADD or SUB, updates C and V

   // Main decoder
   always_comb
   begin
      regSrc      = 2'b00;       // ra1 = rn, ra2 = rm
      immSrc      = IMM_DP8;
      aluSrc      = 1'b0;
      memToReg    = 1'b0;
      regWriteRaw = 1'b0;
      memWriteRaw = 1'b0;
      branch      = 1'b0;
      aluOp       = 1'b0;
      case (op)
         `ARM_OP_DP:
         begin
            aluSrc      = funct[5];   // I bit
            regWriteRaw = 1'b1;
            aluOp       = 1'b1;
         end
         `ARM_OP_MEM:
         begin
            immSrc = IMM_MEM12;
            aluSrc = 1'b1;            // Base plus offset
            if (funct[0])             // L bit, LDR
            begin
               memToReg    = 1'b1;
               regWriteRaw = 1'b1;
            end
            else
            begin
               regSrc[1]   = 1'b1;    // STR data comes from rd
               memWriteRaw = 1'b1;
            end
         end
         `ARM_OP_BR:
         begin
            regSrc[0] = 1'b1;         // PC+8 as base
            immSrc    = IMM_BR24;
            aluSrc    = 1'b1;
            branch    = 1'b1;
         end
         default: ;                   // Op 11, nothing enabled
      endcase
   end

   // ALU decoder
   always_comb
   begin
      aluCtrl = ALU_ADD;              // Address add for LDR/STR/B
      isArith = 1'b0;
      if (aluOp)
      begin
         case (funct[4:1])
            `ARM_CMD_ADD: aluCtrl = ALU_ADD;
            `ARM_CMD_SUB: aluCtrl = ALU_SUB;
            `ARM_CMD_AND: aluCtrl = ALU_AND;
            `ARM_CMD_ORR: aluCtrl = ALU_ORR;
            default:      aluCtrl = ALU_ADD;
         endcase
         isArith = (funct[4:1] == `ARM_CMD_ADD) || (funct[4:1] == `ARM_CMD_SUB);
      end
      flagWriteRaw[FLAG_NZ] = aluOp & funct[0];            // S bit
      flagWriteRaw[FLAG_CV] = aluOp & funct[0] & isArith;  // C/V only for arithmetic
   end

   // Jump on branch or on any write that targets R15
   assign pcWriteRaw = branch | (regWriteRaw & (rd == `ARM_PC_REG));

   // Op 11 would decode to a silent no-op
   always_comb
   begin
      assert final (op !== 2'b11)
         else $error("armDecoder: unsupported op field 11");
   end

endmodule

// ==== design/armCondUnit.sv ====
// NZ and CV flag registers and condition check for every write enable
// A low pcReady blocks all architectural updates; core idles one edge after reset
`timescale 1ns/1ps
`include "armCore_defs.svh"

module armCondUnit
   import armCorePkg::*;
(
   input  logic          clk,
   input  logic          reset,
   input  logic          pcReady,
   input  armCond_t      cond,
   input  armFlags_t     aluFlags,
   input  armFlagWrite_t flagWriteRaw,
   input  logic          regWriteRaw,
   input  logic          memWriteRaw,
   input  logic          pcWriteRaw,
   output logic          regWrite,
   output logic          memWrite,
   output logic          pcLoad,
   output logic          pcStep
);

   logic [1:0]    nzFlags;     // N, Z
   logic [1:0]    cvFlags;     // C, V
   logic          coreRun;     // Set after the first edge out of reset
   logic          condEx;      // Condition holds for current flags
   logic          condOk;      // Condition holds and the cycle may complete
   logic          geFlag;
   armFlagWrite_t flagWrite;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         coreRun <= 1'b0;
      else
         coreRun <= 1'b1;
   end

   // Separate enables, so logical ops keep C and V
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         nzFlags <= 2'b00;
         cvFlags <= 2'b00;
      end
      else
      begin
         if (flagWrite[FLAG_NZ])
            nzFlags <= aluFlags[3:2];
         if (flagWrite[FLAG_CV])
            cvFlags <= aluFlags[1:0];
      end
   end

   assign geFlag = (nzFlags[1] == cvFlags[0]);   // N == V

   // Condition table, flags from before this instruction
   always_comb
   begin
      case (cond)
         4'b0000:      condEx = nzFlags[0];                   // EQ
         4'b0001:      condEx = ~nzFlags[0];                  // NE
         4'b0010:      condEx = cvFlags[1];                   // CS
         4'b0011:      condEx = ~cvFlags[1];                  // CC
         4'b0100:      condEx = nzFlags[1];                   // MI
         4'b0101:      condEx = ~nzFlags[1];                  // PL
         4'b0110:      condEx = cvFlags[0];                   // VS
         4'b0111:      condEx = ~cvFlags[0];                  // VC
         4'b1000:      condEx = cvFlags[1] & ~nzFlags[0];     // HI, unsigned
         4'b1001:      condEx = ~cvFlags[1] | nzFlags[0];     // LS
         4'b1010:      condEx = geFlag;                       // GE, signed
         4'b1011:      condEx = ~geFlag;                      // LT
         4'b1100:      condEx = ~nzFlags[0] & geFlag;         // GT
         4'b1101:      condEx = nzFlags[0] | ~geFlag;         // LE
         `ARM_COND_AL: condEx = 1'b1;
         default:      condEx = 1'b0;                         // 1111 never executes
      endcase
      condOk = condEx & pcReady & coreRun;
      pcStep = pcReady & coreRun & ~pcLoad;   // Sequential advance
   end

   assign flagWrite = flagWriteRaw & {2{condOk}};
   assign regWrite  = regWriteRaw & condOk;
   assign memWrite  = memWriteRaw & condOk;
   assign pcLoad    = pcWriteRaw & condOk;

   // Program must not use the reserved condition
   condNotNv: assert property (@(posedge clk) disable iff (reset) cond != 4'b1111)
      else $error("armCondUnit: reserved condition 1111 fetched");

endmodule

// ==== design/armRegFile.sv ====
// Fifteen general registers, two read ports and one write port
// R15 is not stored here; reads of index 15 return the r15 input
`timescale 1ns/1ps
`include "armCore_defs.svh"

module armRegFile
   import armCorePkg::*;
(
   input  logic        clk,
   input  logic        we,
   input  armRegAddr_t ra1,
   input  armRegAddr_t ra2,
   input  armRegAddr_t wa,
   input  armWord_t    wd,
   input  armWord_t    r15,
   output armWord_t    rd1,
   output armWord_t    rd2
);

   armWord_t regs [0:14];   // R0..R14, no reset

   always_ff @(posedge clk)
   begin
      if (we)
         regs[wa] <= wd;
   end

   // Combinational reads, R15 substituted
   assign rd1 = (ra1 == `ARM_PC_REG) ? r15 : regs[ra1];
   assign rd2 = (ra2 == `ARM_PC_REG) ? r15 : regs[ra2];

   // Datapath routes R15 writes to the PC instead
   noPcWrite: assert property (@(posedge clk) we |-> (wa != `ARM_PC_REG))
      else $error("armRegFile: write to R15 reached the register file");

endmodule

// ==== design/armAlu.sv ====
// 32-bit ALU for ADD, SUB, AND and ORR
// C and V are zero for logical ops; carry-in is not supported
`timescale 1ns/1ps
`include "armCore_defs.svh"

module armAlu
   import armCorePkg::*;
(
   input  armWord_t    a,
   input  armWord_t    b,
   input  armAluCtrl_t aluCtrl,
   output armWord_t    result,
   output armFlags_t   aluFlags
);

   armWord_t          condInvB;   // b or ~b for subtract
   logic [`ARM_XLEN:0] sum;       // Extra bit is the carry out
   logic              isArith;
   logic              isSub;
   logic              negFlag;
   logic              zeroFlag;
   logic              carryFlag;
   logic              ovfFlag;

   assign isSub    = (aluCtrl == ALU_SUB);
   assign isArith  = (aluCtrl == ALU_ADD) || isSub;
   assign condInvB = isSub ? ~b : b;

   // a - b as a + ~b + 1
   assign sum = {1'b0, a} + {1'b0, condInvB} + {{`ARM_XLEN{1'b0}}, isSub};

   always_comb
   begin
      case (aluCtrl)
         ALU_AND: result = a & b;
         ALU_ORR: result = a | b;
         default: result = sum[`ARM_XLEN-1:0];   // ADD, SUB
      endcase
   end

   assign negFlag   = result[`ARM_XLEN-1];
   assign zeroFlag  = (result == '0);
   assign carryFlag = isArith & sum[`ARM_XLEN];   // Carry = no borrow on SUB
   // Same input signs, result sign differs
   assign ovfFlag   = isArith
                    & (a[`ARM_XLEN-1] == condInvB[`ARM_XLEN-1])
                    & (a[`ARM_XLEN-1] ^ sum[`ARM_XLEN-1]);

   assign aluFlags = {negFlag, zeroFlag, carryFlag, ovfFlag};

endmodule

// ==== design/armDatapath.sv ====
// PC, register file, immediate extension, ALU and result select
// R15 writes go to the PC only, via pcLoad
`timescale 1ns/1ps
`include "armCore_defs.svh"

module armDatapath
   import armCorePkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        regWrite,
   input  logic        pcLoad,
   input  logic        pcStep,
   input  logic        memToReg,
   input  logic        aluSrc,
   input  logic [1:0]  regSrc,
   input  armImmSrc_t  immSrc,
   input  armAluCtrl_t aluCtrl,
   input  armWord_t    instr,
   input  armWord_t    readData,
   output armWord_t    pc,
   output armWord_t    aluResult,
   output armWord_t    writeData,
   output armFlags_t   aluFlags
);

   armWord_t    pcPlus4;
   armWord_t    pcPlus8;   // R15 read value
   armWord_t    extImm;
   armWord_t    srcA;
   armWord_t    srcB;
   armWord_t    result;    // Register write data and jump target
   armRegAddr_t ra1;
   armRegAddr_t ra2;
   armRegAddr_t wa;
   logic        rfWe;

   assign pcPlus4 = pc + `ARM_PC_STEP;
   assign pcPlus8 = pcPlus4 + `ARM_PC_STEP;

   // Holds when neither load nor step, i.e. stalled
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         pc <= `ARM_RESET_PC;
      else if (pcLoad)
         pc <= result;       // B target, LDR or DP into R15
      else if (pcStep)
         pc <= pcPlus4;
   end

   // Register addresses
   assign ra1 = regSrc[0] ? `ARM_PC_REG : instr[19:16];      // R15 base for B
   assign ra2 = regSrc[1] ? instr[15:12] : instr[3:0];       // rd is STR data
   assign wa  = instr[15:12];
   assign rfWe = regWrite & (wa != `ARM_PC_REG);            // R15 handled by pcLoad

   armRegFile regFile_i (
      .clk (clk),
      .we  (rfWe),
      .ra1 (ra1),
      .ra2 (ra2),
      .wa  (wa),
      .wd  (result),
      .r15 (pcPlus8),
      .rd1 (srcA),
      .rd2 (writeData)
   );

   // Immediate extension
   always_comb
   begin
      case (immSrc)
         IMM_DP8:   extImm = {{(`ARM_XLEN-8){1'b0}}, instr[7:0]};
         IMM_MEM12: extImm = {{(`ARM_XLEN-12){1'b0}}, instr[11:0]};
         IMM_BR24:  extImm = {{(`ARM_XLEN-`ARM_IMM_W-2){instr[`ARM_IMM_W-1]}},
                             instr[`ARM_IMM_W-1:0], 2'b00};   // Word offset
         default:   extImm = '0;
      endcase
   end

   assign srcB = aluSrc ? extImm : writeData;

   armAlu alu_i (
      .a        (srcA),
      .b        (srcB),
      .aluCtrl  (aluCtrl),
      .result   (aluResult),
      .aluFlags (aluFlags)
   );

   assign result = memToReg ? readData : aluResult;   // LDR returns memory word

endmodule

// ==== design/armCore.sv ====
// Single-cycle ARMv4 subset core, combinational instruction and data memories
// pcReady low holds PC, registers and flags and keeps memWrite low
`timescale 1ns/1ps
`include "armCore_defs.svh"

module armCore
   import armCorePkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     pcReady,
   input  armWord_t instr,
   input  armWord_t readData,
   output armWord_t pc,
   output armWord_t aluResult,
   output armWord_t writeData,
   output logic     memWrite
);

   armFlags_t     aluFlags;
   armFlagWrite_t flagWriteRaw;
   armImmSrc_t    immSrc;
   armAluCtrl_t   aluCtrl;
   logic [1:0]    regSrc;
   logic          regWriteRaw;
   logic          memWriteRaw;
   logic          pcWriteRaw;
   logic          memToReg;
   logic          aluSrc;
   logic          regWrite;
   logic          pcLoad;
   logic          pcStep;

   armDecoder decoder_i (
      .op           (instr[27:26]),
      .funct        (instr[25:20]),
      .rd           (instr[15:12]),
      .regWriteRaw  (regWriteRaw),
      .memWriteRaw  (memWriteRaw),
      .pcWriteRaw   (pcWriteRaw),
      .memToReg     (memToReg),
      .aluSrc       (aluSrc),
      .regSrc       (regSrc),
      .immSrc       (immSrc),
      .aluCtrl      (aluCtrl),
      .flagWriteRaw (flagWriteRaw)
   );

   armCondUnit condUnit_i (
      .clk          (clk),
      .reset        (reset),
      .pcReady      (pcReady),
      .cond         (instr[31:28]),
      .aluFlags     (aluFlags),
      .flagWriteRaw (flagWriteRaw),
      .regWriteRaw  (regWriteRaw),
      .memWriteRaw  (memWriteRaw),
      .pcWriteRaw   (pcWriteRaw),
      .regWrite     (regWrite),
      .memWrite     (memWrite),
      .pcLoad       (pcLoad),
      .pcStep       (pcStep)
   );

   armDatapath datapath_i (
      .clk       (clk),
      .reset     (reset),
      .regWrite  (regWrite),
      .pcLoad    (pcLoad),
      .pcStep    (pcStep),
      .memToReg  (memToReg),
      .aluSrc    (aluSrc),
      .regSrc    (regSrc),
      .immSrc    (immSrc),
      .aluCtrl   (aluCtrl),
      .instr     (instr),
      .readData  (readData),
      .pc        (pc),
      .aluResult (aluResult),
      .writeData (writeData),
      .aluFlags  (aluFlags)
   );

endmodule

// ==== verification/armCoreTbMem.sv ====
// Test program ROM and data RAM, both indexed by address bits 9:2 (1 KB, aliased above)
// Stores are reported one cycle after the edge that wrote them
`timescale 1ns/1ps
`include "armCore_defs.svh"

module armCoreTbMem
   import armCorePkg::*;
(
   input  logic     clk,
   input  armWord_t pc,
   input  armWord_t addr,
   input  armWord_t writeData,
   input  logic     memWrite,
   output armWord_t instr,
   output armWord_t readData,
   output logic     wrStrobe,    // High one cycle per completed store
   output armWord_t wrAddr,
   output armWord_t wrData
);

   localparam logic [3:0]  AL       = `ARM_COND_AL;
   localparam logic [3:0]  NE       = 4'b0001;
   localparam logic [15:0] CMD_LIST = {`ARM_CMD_ADD, `ARM_CMD_SUB, `ARM_CMD_AND, `ARM_CMD_ORR};
   localparam logic [31:0] IMM_LIST = {8'd100, 8'd5, 8'h0F, 8'hC0};   // Per CMD_LIST entry

   armWord_t rom [0:255];
   armWord_t dataRam [0:255];
   int       nextIdx;
   int       loopIdx;

   // Always-executed data processing, rotate and shift fields zero
   function automatic armWord_t dpInstr(logic [3:0] cmd, logic s, logic [3:0] rn,
                                        logic [3:0] rd, logic isImm, logic [7:0] op2);
      return {AL, `ARM_OP_DP, isImm, cmd, s, rn, rd, 4'b0000, op2};
   endfunction

   // Pre-indexed, offset added, no writeback
   function automatic armWord_t memInstr(logic [3:0] cond, logic isLoad, logic [3:0] rn,
                                         logic [3:0] rd, logic [11:0] offset);
      return {cond, `ARM_OP_MEM, 5'b01100, isLoad, rn, rd, offset};
   endfunction

   function automatic armWord_t brInstr(logic [3:0] cond, int offset);
      return {cond, `ARM_OP_BR, 2'b10, offset[23:0]};   // Words from PC+8
   endfunction

   task automatic put(armWord_t word);
      rom[nextIdx] = word;
      nextIdx++;
   endtask

   initial
   begin
      wrStrobe = 1'b0;
      for (int i = 0; i < 256; i++)
      begin
         rom[i]     = dpInstr(`ARM_CMD_AND, 1'b0, 4'd13, 4'd13, 1'b1, i[7:0]);   // Harmless filler
         dataRam[i] = 32'hF111_0000 | armWord_t'(i << 2);
      end
      nextIdx = 0;
      put(memInstr(AL, 1'b0, 4'd15, 4'd15, 12'd188));             // Store at reset PC, slot 17
      put(dpInstr(`ARM_CMD_AND, 1'b0, 4'd0, 4'd0, 1'b1, 8'd0));    // r0 = 0 even from X
      put(dpInstr(`ARM_CMD_ADD, 1'b0, 4'd0, 4'd10, 1'b1, 8'h80));  // r10 slot base
      put(dpInstr(`ARM_CMD_ADD, 1'b0, 4'd15, 4'd11, 1'b1, 8'd0));  // r11 = R15 at word 3
      put(dpInstr(`ARM_CMD_ADD, 1'b0, 4'd0, 4'd1, 1'b1, 8'd25));
      put(dpInstr(`ARM_CMD_ADD, 1'b0, 4'd0, 4'd2, 1'b1, 8'd17));
      put(memInstr(AL, 1'b0, 4'd10, 4'd11, 12'd32));              // Slot 8
      // Each op with an immediate, then with r2, into slots 0..7
      for (int k = 0; k < 8; k++)
      begin
         put(dpInstr(CMD_LIST[(3 - k / 2) * 4 +: 4], 1'b0, 4'd1, 4'd3, ~k[0],
                     k[0] ? 8'd2 : IMM_LIST[(3 - k / 2) * 8 +: 8]));
         put(memInstr(AL, 1'b0, 4'd10, 4'd3, 12'(k * 4)));
      end
      // Doubling loop of 31 passes, r8 counts
      put(dpInstr(`ARM_CMD_ADD, 1'b0, 4'd0, 4'd5, 1'b1, 8'd1));
      put(dpInstr(`ARM_CMD_ADD, 1'b0, 4'd0, 4'd7, 1'b1, 8'd31));
      put(dpInstr(`ARM_CMD_ADD, 1'b0, 4'd0, 4'd8, 1'b1, 8'd0));
      loopIdx = nextIdx;
      put(dpInstr(`ARM_CMD_ADD, 1'b0, 4'd5, 4'd5, 1'b0, 8'd5));
      put(dpInstr(`ARM_CMD_ADD, 1'b0, 4'd8, 4'd8, 1'b1, 8'd1));
      put(dpInstr(`ARM_CMD_SUB, 1'b1, 4'd7, 4'd7, 1'b1, 8'd1));   // SUBS sets Z at zero
      put(brInstr(NE, loopIdx - nextIdx - 2));
      put(memInstr(AL, 1'b0, 4'd10, 4'd8, 12'd44));              // Slot 11
      put(memInstr(AL, 1'b0, 4'd10, 4'd5, 12'd48));              // Slot 12
      // Store, load back through a second base, store again
      put(dpInstr(`ARM_CMD_ADD, 1'b0, 4'd10, 4'd12, 1'b1, 8'd16));
      put(memInstr(AL, 1'b0, 4'd12, 4'd5, 12'd20));              // Slot 9
      put(memInstr(AL, 1'b1, 4'd12, 4'd6, 12'd20));
      put(memInstr(AL, 1'b0, 4'd10, 4'd6, 12'd40));              // Slot 10
      put(brInstr(AL, 0));                                        // Skips the next word
      put(memInstr(AL, 1'b0, 4'd10, 4'd1, 12'd60));              // Slot 15, never
      put(memInstr(AL, 1'b0, 4'd10, 4'd2, 12'd52));              // Slot 13
      put(dpInstr(`ARM_CMD_ADD, 1'b0, 4'd15, 4'd15, 1'b1, 8'd0)); // Jump to PC+8
      put(memInstr(AL, 1'b0, 4'd10, 4'd1, 12'd64));              // Slot 16, never
      put(memInstr(AL, 1'b0, 4'd10, 4'd1, 12'd56));              // Slot 14
      // Five flag cases, each followed by stores under conditions 0..13
      for (int c = 0; c < 5; c++)
      begin
         case (c)
            0:       put(dpInstr(`ARM_CMD_SUB, 1'b1, 4'd1, 4'd4, 1'b0, 8'd2));   // 25 - 17
            1:       put(dpInstr(`ARM_CMD_SUB, 1'b1, 4'd1, 4'd4, 1'b0, 8'd1));   // 25 - 25
            2:       put(dpInstr(`ARM_CMD_SUB, 1'b1, 4'd2, 4'd4, 1'b0, 8'd1));   // 17 - 25
            3:       put(dpInstr(`ARM_CMD_SUB, 1'b1, 4'd5, 4'd4, 1'b1, 8'd1));   // Min - 1
            default: put(dpInstr(`ARM_CMD_ADD, 1'b1, 4'd4, 4'd4, 1'b1, 8'd1));   // Max + 1
         endcase
         for (int cc = 0; cc < 14; cc++)
            put(memInstr(cc[3:0], 1'b0, 4'd10, 4'd1, 12'((20 + c * 14 + cc) * 4)));
      end
      put(memInstr(AL, 1'b0, 4'd0, 4'd1, 12'h3FC));   // End marker
      put(brInstr(AL, -2));                            // Park here
   end

   assign instr    = rom[pc[9:2]];
   assign readData = dataRam[addr[9:2]];

   always @(posedge clk)
   begin
      if (memWrite)
         dataRam[addr[9:2]] <= writeData;
      wrStrobe <= memWrite;
      wrAddr   <= addr;
      wrData   <= writeData;
   end

endmodule

// ==== verification/armCoreTb.sv ====
// Self-checking testbench, random pcReady gaps from a fixed seed
// Slot layout must match the program in the memory model
`timescale 1ns/1ps
`include "armCore_defs.svh"

module armCoreTb
   import armCorePkg::*;
();

   localparam int       SLOT_BASE      = 32;       // Word index of address 0x80
   localparam int       COND_SLOT      = 20;
   localparam armWord_t R15_INSTR_ADDR = 32'hC;    // Fourth ROM word
   localparam armWord_t DONE_ADDR      = 32'h3FC;
   localparam int       RUN_TIMEOUT    = 5000;

   logic     clk;
   logic     reset;
   logic     pcReady;
   logic     memWrite;
   logic     wrStrobe;
   logic     doneSeen;
   armWord_t instr;
   armWord_t readData;
   armWord_t pc;
   armWord_t aluResult;
   armWord_t writeData;
   armWord_t wrAddr;
   armWord_t wrData;
   armWord_t pcHist1;
   armWord_t pcHist2;      // PC before the previous edge
   logic     expValid [0:255];
   armWord_t expWord [0:255];
   string    expName [0:255];
   integer   seed;
   int       errors;
   int       timeouts;
   int       storesSeen;
   int       waitCycles;

   armCore dut_i (
      .clk       (clk),
      .reset     (reset),
      .pcReady   (pcReady),
      .instr     (instr),
      .readData  (readData),
      .pc        (pc),
      .aluResult (aluResult),
      .writeData (writeData),
      .memWrite  (memWrite)
   );

   armCoreTbMem mem_i (
      .clk       (clk),
      .pc        (pc),
      .addr      (aluResult),
      .writeData (writeData),
      .memWrite  (memWrite),
      .instr     (instr),
      .readData  (readData),
      .wrStrobe  (wrStrobe),
      .wrAddr    (wrAddr),
      .wrData    (wrData)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial
   begin
      seed    = 52681;
      pcReady = 1'b1;
      forever
      begin
         @(negedge clk);
         pcReady = ($random(seed) & 3) != 0;   // Low about one cycle in four
      end
   end

   always @(posedge clk)
   begin
      pcHist1 <= pc;
      pcHist2 <= pcHist1;
   end

   always @(negedge clk)
   begin
      if (!reset && wrStrobe)
         storesSeen++;
   end

   // NZCV after ADD or SUB, ARM rules
   function automatic armFlags_t arithFlags(armWord_t a, armWord_t b, logic isSub);
      logic [32:0] wide;
      logic        v;
      wide = isSub ? ({1'b0, a} - {1'b0, b}) : ({1'b0, a} + {1'b0, b});
      if (isSub)
         v = (a[31] != b[31]) && (wide[31] != a[31]);
      else
         v = (a[31] == b[31]) && (wide[31] != a[31]);
      return {wide[31], wide[31:0] == 32'd0, isSub ? ~wide[32] : wide[32], v};   // C = no borrow
   endfunction

   function automatic logic condHolds(logic [3:0] cond, armFlags_t f);
      case (cond)
         4'd0:    return f[2];
         4'd1:    return !f[2];
         4'd2:    return f[1];
         4'd3:    return !f[1];
         4'd4:    return f[3];
         4'd5:    return !f[3];
         4'd6:    return f[0];
         4'd7:    return !f[0];
         4'd8:    return f[1] && !f[2];
         4'd9:    return !f[1] || f[2];
         4'd10:   return f[3] == f[0];
         4'd11:   return f[3] != f[0];
         4'd12:   return !f[2] && (f[3] == f[0]);
         4'd13:   return f[2] || (f[3] != f[0]);
         default: return 1'b1;
      endcase
   endfunction

   function automatic armWord_t aluRule(int op, armWord_t a, armWord_t b);
      case (op)
         0:       return a + b;
         1:       return a - b;
         2:       return a & b;
         default: return a | b;
      endcase
   endfunction

   function automatic armWord_t ramFill(int idx);
      return 32'hF111_0000 | armWord_t'(idx * 4);
   endfunction

   task automatic expectStore(int idx, armWord_t value, string name);
      expValid[idx] = 1'b1;
      expWord[idx]  = value;
      expName[idx]  = name;
   endtask

   task automatic buildScoreboard();
      armWord_t  aluImm [4];
      armWord_t  condA [5];
      armWord_t  condB [5];
      logic      condSub [5];
      string     opNames [4];
      armFlags_t f;
      aluImm  = '{32'd100, 32'd5, 32'h0F, 32'hC0};
      opNames = '{"add", "sub", "and", "orr"};
      condA   = '{32'd25, 32'd25, 32'd17, 32'h8000_0000, 32'h7FFF_FFFF};
      condB   = '{32'd17, 32'd25, 32'd25, 32'd1, 32'd1};
      condSub = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0};
      for (int i = 0; i < 256; i++)
         expValid[i] = 1'b0;
      for (int k = 0; k < 8; k++)
         expectStore(SLOT_BASE + k, aluRule(k / 2, 32'd25, k[0] ? 32'd17 : aluImm[k / 2]),
                     $sformatf("%s%s", opNames[k / 2], k[0] ? "Reg" : "Imm"));
      expectStore(SLOT_BASE + 8, R15_INSTR_ADDR + 8, "r15Read");
      expectStore(SLOT_BASE + 9, 32'h1 << 31, "strFirst");
      expectStore(SLOT_BASE + 10, 32'h1 << 31, "ldrBack");
      expectStore(SLOT_BASE + 11, 32'd31, "loopCount");
      expectStore(SLOT_BASE + 12, 32'h1 << 31, "loopDouble");   // 1 doubled 31 times
      expectStore(SLOT_BASE + 13, 32'd17, "afterB");
      expectStore(SLOT_BASE + 14, 32'd25, "afterPcWrite");
      // Slots 15 and 16 sit behind jumps and keep their fill
      expectStore(SLOT_BASE + 17, `ARM_RESET_PC + 8, "resetStore");   // R15 of the first word
      for (int c = 0; c < 5; c++)
      begin
         f = arithFlags(condA[c], condB[c], condSub[c]);
         for (int cc = 0; cc < 14; cc++)
            if (condHolds(cc[3:0], f))
               expectStore(SLOT_BASE + COND_SLOT + c * 14 + cc, 32'd25,
                           $sformatf("flags%0d_cond%0d", c, cc));
      end
      expectStore(int'(DONE_ADDR[9:2]), 32'd25, "doneMarker");
   endtask

   // Final RAM against the stall-free expectation
   task automatic checkImage();
      armWord_t want;
      for (int i = 0; i < 256; i++)
      begin
         want = expValid[i] ? expWord[i] : ramFill(i);
         assert (mem_i.dataRam[i] === want)
            else
            begin
               errors++;
               $display("Error image %s at %h: expected %h actual %h",
                        expValid[i] ? expName[i] : "untouched", i * 4, want, mem_i.dataRam[i]);
            end
      end
   endtask

   resetPc: assert property (@(posedge clk) reset |-> pc == `ARM_RESET_PC)
      else
      begin
         errors++;
         $display("Error resetPc: expected %h actual %h", `ARM_RESET_PC, $sampled(pc));
      end

   resetMemWrite: assert property (@(posedge clk) reset |-> !memWrite)
      else
      begin
         errors++;
         $display("Error resetMemWrite: expected 0 actual %b", $sampled(memWrite));
      end

   stallMemWrite: assert property (@(posedge clk) disable iff (reset) !pcReady |-> !memWrite)
      else
      begin
         errors++;
         $display("Error stallMemWrite: expected 0 actual %b", $sampled(memWrite));
      end

   stallPc: assert property (@(posedge clk) disable iff (reset) !pcReady |=> pc == $past(pc))
      else
      begin
         errors++;
         $display("Error stallPc: expected %h actual %h", pcHist2, $sampled(pc));
      end

   // Any store outside the table is one that should have been skipped
   storeAddr: assert property (@(posedge clk) disable iff (reset)
      wrStrobe |-> (wrAddr[31:10] == '0 && wrAddr[1:0] == 2'b00 && expValid[wrAddr[9:2]]))
      else
      begin
         errors++;
         $display("Unexpected store of %h to address %h", $sampled(wrData), $sampled(wrAddr));
      end

   storeData: assert property (@(posedge clk) disable iff (reset)
      (wrStrobe && expValid[wrAddr[9:2]]) |-> wrData == expWord[wrAddr[9:2]])
      else
      begin
         errors++;
         $display("Error %s: expected %h actual %h", expName[$sampled(wrAddr[9:2])],
                  expWord[$sampled(wrAddr[9:2])], $sampled(wrData));
      end

   initial
   begin
      reset      = 1'b1;
      errors     = 0;
      timeouts   = 0;
      storesSeen = 0;
      doneSeen   = 1'b0;
      buildScoreboard();
      repeat (16) @(negedge clk);
      reset = 1'b0;
      waitCycles = 0;
      while (!doneSeen && waitCycles < RUN_TIMEOUT)
      begin
         @(negedge clk);
         waitCycles++;
         doneSeen = wrStrobe && (wrAddr == DONE_ADDR);
      end
      if (!doneSeen)
      begin
         timeouts++;
         $display("Timeout: the program never stored to the end marker at %h", DONE_ADDR);
      end
      @(posedge clk);   // Marker store reaches its assertions
      @(negedge clk);
      checkImage();
      $display("Errors: %0d, timeouts: %0d, stores seen: %0d", errors, timeouts, storesSeen);
      if (errors == 0 && timeouts == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

// ==== armCore.f ====
+incdir+design
design/armCorePkg.sv
design/armDecoder.sv
design/armCondUnit.sv
design/armRegFile.sv
design/armAlu.sv
design/armDatapath.sv
design/armCore.sv
verification/armCoreTbMem.sv
verification/armCoreTb.sv
